// File: verif/rvv_input.txt
// columns: tag f1 f2 f3 f4 f5 in hex; tag 1 preload addr data, tag 3 check stored addr data
// tag 2 insn: kind (0 none 1 cfg 2 load 3 store) insn rs1 rs2 expected (rd, or wen count)
1 00000100 a1b2c300 0 0 0
1 00000104 1f2e3d01 0 0 0
1 00000108 55aa0f02 0 0 0
1 0000010c deadbe03 0 0 0
1 00000110 0badf004 0 0 0
1 00000114 7c6b5a05 0 0 0
2 1 010572d7 00000003 00000000 00000003
2 1 c113f357 00000000 00000000 00000007
2 1 80c5f3d7 00000014 00000012 00000010
2 1 01107457 00000005 00000000 00000008
2 1 014572d7 00000004 00000000 00000000
2 2 02056207 00000100 00000000 00000000
2 1 c1137357 00000000 00000000 00000006
2 2 02056207 00000100 00000000 00000006
2 3 0205e227 00000200 00000000 00000006
3 00000200 a1b2c300 0 0 0
3 00000204 1f2e3d01 0 0 0
3 00000208 55aa0f02 0 0 0
3 0000020c deadbe03 0 0 0
3 00000210 0badf004 0 0 0
3 00000214 7c6b5a05 0 0 0
3 00000218 c0de0218 0 0 0
2 0 003100b3 00000000 00000000 00000000
2 0 022180d7 00000000 00000000 00000000
2 0 02050207 00000000 00000000 00000000
0 0 0 0 0 0

// File: tb.f
design/rvv_isa_pkg.sv
design/rvv_state_pkg.sv
design/rvv_decode.sv
design/rvv_csr.sv
design/rvv_lsu.sv
design/rvv_vregs.sv
design/rvv_pcpi_top.sv
verif/tb_clk_gen.sv
verif/rvv_chk.sv
verif/tb_rvv.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_rvv -f tb.f -o Vtb_rvv
status=0
./obj_dir/Vtb_rvv > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: verif/tb_rvv.sv
`timescale 1ns/1ps

module tb_rvv;
	localparam int unsigned VLEN          = 128;
	localparam int          STIM_WORDS    = 384; // six words per record
	localparam int          READY_TIMEOUT = 200;
	localparam int          RESET_TIMEOUT = 100;
	localparam logic [31:0] REC_END       = 32'd0;
	localparam logic [31:0] REC_PRELOAD   = 32'd1;
	localparam logic [31:0] REC_INSN      = 32'd2;
	localparam logic [31:0] REC_STORE     = 32'd3;
	localparam logic [31:0] KIND_NONE     = 32'd0;
	localparam logic [31:0] KIND_CFG      = 32'd1;
	localparam logic [31:0] KIND_LOAD     = 32'd2;
	localparam logic [31:0] KIND_STORE    = 32'd3;

	logic        clk;
	logic        resetn;
	logic        pcpi_valid;
	logic [31:0] pcpi_insn;
	logic [31:0] pcpi_rs1;
	logic [31:0] pcpi_rs2;
	logic [31:0] mem_rdata;
	logic        mem_done;
	logic        pcpi_wr_o, pcpi_wait_o, pcpi_ready_o, pcpi_is_rvv_o;
	logic        pcpi_mem_op_o, pcpi_mem_load_o, pcpi_mem_store_o;
	logic        pcpi_mem_wen_o, pcpi_mem_ftrans_o;
	logic [31:0] pcpi_rd_o, pcpi_mem_addr_o, pcpi_mem_wdata_o;
	logic [3:0]  pcpi_mem_strb_o;

	logic [31:0] stim [0:STIM_WORDS-1];
	logic [31:0] mem_words [0:255]; // word index is addr[9:2]
	logic        req_pend;
	int          req_delay;
	logic [31:0] req_addr;
	int          err_cnt;
	int          timeout_cnt;

	tb_clk_gen i_tb_clk_gen (
		.clk    (clk),
		.resetn (resetn)
	);

	rvv_pcpi_top #(
		.VLEN           (VLEN),
		.REGS_INIT_ZERO (1'b1)
	) i_rvv_pcpi_top (
		.clk               (clk),
		.resetn            (resetn),
		.pcpi_valid_i      (pcpi_valid),
		.pcpi_insn_i       (pcpi_insn),
		.pcpi_rs1_i        (pcpi_rs1),
		.pcpi_rs2_i        (pcpi_rs2),
		.pcpi_mem_rdata_i  (mem_rdata),
		.pcpi_mem_done_i   (mem_done),
		.pcpi_wr_o         (pcpi_wr_o),
		.pcpi_rd_o         (pcpi_rd_o),
		.pcpi_wait_o       (pcpi_wait_o),
		.pcpi_ready_o      (pcpi_ready_o),
		.pcpi_is_rvv_o     (pcpi_is_rvv_o),
		.pcpi_mem_op_o     (pcpi_mem_op_o),
		.pcpi_mem_load_o   (pcpi_mem_load_o),
		.pcpi_mem_store_o  (pcpi_mem_store_o),
		.pcpi_mem_wen_o    (pcpi_mem_wen_o),
		.pcpi_mem_ftrans_o (pcpi_mem_ftrans_o),
		.pcpi_mem_addr_o   (pcpi_mem_addr_o),
		.pcpi_mem_wdata_o  (pcpi_mem_wdata_o),
		.pcpi_mem_strb_o   (pcpi_mem_strb_o)
	);

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// one cycle of the core memory, called right after each rising edge
	task automatic serve_memory(input logic [31:0] base, inout int wen_cnt);
		mem_done <= 1'b0;
		if (req_pend) begin
			if (pcpi_mem_wen_o) begin
				err_cnt++;
				$display("request issued while the previous one was still pending");
			end
			if (req_delay == 0) begin
				mem_done <= 1'b1;
				mem_rdata <= mem_words[req_addr[9:2]];
				req_pend = 1'b0;
			end else begin
				req_delay--;
			end
		end else if (pcpi_mem_wen_o) begin
			compare_value("pcpi_mem_ftrans_o", 32'(pcpi_mem_ftrans_o), 32'(wen_cnt == 0));
			compare_value("pcpi_mem_addr_o", pcpi_mem_addr_o, base + 32'(wen_cnt) * 32'd4);
			if (pcpi_mem_store_o) begin
				compare_value("pcpi_mem_strb_o", 32'(pcpi_mem_strb_o), 32'hf);
				mem_words[pcpi_mem_addr_o[9:2]] = pcpi_mem_wdata_o;
			end
			req_addr = pcpi_mem_addr_o;
			req_delay = $urandom % 4; // done after 0 to 3 idle cycles
			req_pend = 1'b1;
			wen_cnt++;
		end else if (pcpi_mem_ftrans_o) begin
			compare_value("pcpi_mem_ftrans_o", 32'(pcpi_mem_ftrans_o), 32'd0);
		end
	endtask

	task automatic run_insn(input logic [31:0] kind, input logic [31:0] insn,
		input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] expected);
		int          cycles;
		int          wen_cnt;
		logic        got_ready;
		logic        wr_seen;
		logic [31:0] rd_seen;
		cycles = 0;
		wen_cnt = 0;
		got_ready = 1'b0;
		wr_seen = 1'b0;
		rd_seen = '0;
		@(posedge clk);
		pcpi_insn <= insn;
		pcpi_rs1 <= rs1;
		pcpi_rs2 <= rs2;
		if (kind == KIND_NONE) begin
			@(posedge clk);
			compare_value("pcpi_is_rvv_o", 32'(pcpi_is_rvv_o), 32'd0);
			compare_value("pcpi_mem_load_o", 32'(pcpi_mem_load_o), 32'd0);
			compare_value("pcpi_mem_store_o", 32'(pcpi_mem_store_o), 32'd0);
			return;
		end
		pcpi_valid <= 1'b1;
		while (!got_ready && cycles < READY_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			if (cycles == 1) begin
				compare_value("pcpi_is_rvv_o", 32'(pcpi_is_rvv_o), 32'd1);
				compare_value("pcpi_mem_load_o", 32'(pcpi_mem_load_o),
					32'(kind == KIND_LOAD));
				compare_value("pcpi_mem_store_o", 32'(pcpi_mem_store_o),
					32'(kind == KIND_STORE));
			end
			serve_memory(rs1, wen_cnt);
			if (pcpi_ready_o) begin
				got_ready = 1'b1;
				wr_seen = pcpi_wr_o;
				rd_seen = pcpi_rd_o;
				pcpi_valid <= 1'b0;
			end else if (kind != KIND_CFG && cycles >= 2) begin
				compare_value("pcpi_wait_o", 32'(pcpi_wait_o), 32'd1);
				compare_value("pcpi_mem_op_o", 32'(pcpi_mem_op_o), 32'd1);
			end
		end
		if (!got_ready) begin
			timeout_cnt++;
			$display("timeout: no ready for instruction %h", insn);
			return;
		end
		if (kind == KIND_CFG) begin
			compare_value("ready latency", 32'(cycles), 32'd2);
			compare_value("pcpi_wr_o", 32'(wr_seen), 32'd1);
			compare_value("pcpi_rd_o", rd_seen, expected);
		end else begin
			compare_value("wen count", 32'(wen_cnt), expected);
			if (expected == 32'd0)
				compare_value("ready latency", 32'(cycles), 32'd2);
		end
	endtask

	initial begin
		int   p;
		int   rst_cycles;
		logic stop;
		err_cnt = 0;
		timeout_cnt = 0;
		pcpi_valid <= 1'b0;
		pcpi_insn <= '0;
		pcpi_rs1 <= '0;
		pcpi_rs2 <= '0;
		mem_rdata <= '0;
		mem_done <= 1'b0;
		req_pend = 1'b0;
		req_delay = 0;
		req_addr = '0;
		void'($urandom(32'h3c7945e9));
		for (int i = 0; i < 256; i++)
			mem_words[i] = 32'hc0de0000 ^ (i << 2); // byte address in the low bits
		$readmemh("verif/rvv_input.txt", stim);

		rst_cycles = 0;
		while (resetn !== 1'b1 && rst_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			rst_cycles++;
		end
		if (resetn !== 1'b1) begin
			timeout_cnt++;
			$display("timeout: reset was never released");
		end

		p = 0;
		stop = timeout_cnt != 0;
		while (!stop && p + 5 < STIM_WORDS) begin
			case (stim[p])
				REC_PRELOAD: mem_words[stim[p+1][9:2]] = stim[p+2];
				REC_INSN: begin
					run_insn(stim[p+1], stim[p+2], stim[p+3], stim[p+4], stim[p+5]);
					stop = timeout_cnt != 0;
				end
				REC_STORE: compare_value("stored word", mem_words[stim[p+1][9:2]], stim[p+2]);
				REC_END: stop = 1'b1;
				default: begin
					err_cnt++;
					$display("unknown record tag %h at word %0d of the input file", stim[p], p);
					stop = 1'b1;
				end
			endcase
			p += 6;
		end

		$display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: verif/rvv_chk.sv
`timescale 1ns/1ps

module rvv_chk (
	input logic clk,
	input logic resetn,
	input logic ready_i,
	input logic wait_i,
	input logic mem_wen_i,
	input logic mem_op_i
);
	a_ready_wait: assert property (@(posedge clk) disable iff (!resetn) !(ready_i && wait_i))
		else $error("ready and wait high in the same cycle");

	// requests only inside a memory instruction
	a_wen_op: assert property (@(posedge clk) disable iff (!resetn) mem_wen_i |-> mem_op_i)
		else $error("wen high while mem_op is low");

	a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn) ready_i |=> !ready_i)
		else $error("ready held for two cycles");

endmodule

bind rvv_pcpi_top rvv_chk i_rvv_chk (
	.clk       (clk),
	.resetn    (resetn),
	.ready_i   (pcpi_ready_o),
	.wait_i    (pcpi_wait_o),
	.mem_wen_i (pcpi_mem_wen_o),
	.mem_op_i  (pcpi_mem_op_o)
);

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int unsigned HALF_PERIOD  = 20,
	parameter int unsigned RESET_CYCLES = 16
) (
	output logic clk,
	output logic resetn
);
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk; // 40 ns period
	end

	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

// File: design/rvv_pcpi_top.sv
`timescale 1ns/1ps

module rvv_pcpi_top #(
	parameter int unsigned VLEN           = 128,
	parameter bit          REGS_INIT_ZERO = 1'b0
) (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [31:0] pcpi_rs2_i,
	input  logic [31:0] pcpi_mem_rdata_i,
	input  logic        pcpi_mem_done_i,
	output logic        pcpi_wr_o,
	output logic [31:0] pcpi_rd_o,
	output logic        pcpi_wait_o,
	output logic        pcpi_ready_o,
	output logic        pcpi_is_rvv_o,
	output logic        pcpi_mem_op_o,
	output logic        pcpi_mem_load_o,
	output logic        pcpi_mem_store_o,
	output logic        pcpi_mem_wen_o,
	output logic        pcpi_mem_ftrans_o,
	output logic [31:0] pcpi_mem_addr_o,
	output logic [31:0] pcpi_mem_wdata_o,
	output logic [3:0]  pcpi_mem_strb_o
);
	rvv_isa_pkg::rvv_op_t    op;
	rvv_state_pkg::vtype_t   vtype;
	rvv_state_pkg::mem_req_t mem_req;
	logic [31:0]       vl;
	logic              run;
	logic              csr_ready;
	logic              lsu_ready;
	logic              lsu_wait;
	logic [4:0]        vreg_raddr;
	logic [4:0]        vreg_waddr;
	logic [VLEN/8-1:0] vreg_wstrb;
	logic [VLEN-1:0]   vreg_wdata;
	logic [VLEN-1:0]   vreg_rdata;

	assign run = pcpi_valid_i && !pcpi_ready_o; // core holds valid until ready
	assign pcpi_ready_o = csr_ready | lsu_ready;
	assign pcpi_wait_o = lsu_wait;
	assign pcpi_is_rvv_o = op.kind != rvv_isa_pkg::KIND_NONE;

	assign pcpi_mem_op_o = lsu_wait;
	assign pcpi_mem_load_o = op.kind == rvv_isa_pkg::KIND_LOAD;
	assign pcpi_mem_store_o = op.kind == rvv_isa_pkg::KIND_STORE;
	assign pcpi_mem_wen_o = mem_req.wen;
	assign pcpi_mem_ftrans_o = mem_req.ftrans;
	assign pcpi_mem_addr_o = mem_req.addr;
	assign pcpi_mem_wdata_o = mem_req.wdata;
	assign pcpi_mem_strb_o = mem_req.strb;

	rvv_decode i_rvv_decode (
		.pcpi_insn_i (pcpi_insn_i),
		.op_o        (op)
	);

	rvv_csr #(
		.VLEN (VLEN)
	) i_rvv_csr (
		.clk     (clk),
		.resetn  (resetn),
		.run_i   (run),
		.op_i    (op),
		.rs1_i   (pcpi_rs1_i),
		.rs2_i   (pcpi_rs2_i),
		.vtype_o (vtype),
		.vl_o    (vl),
		.ready_o (csr_ready),
		.wr_o    (pcpi_wr_o),
		.rd_o    (pcpi_rd_o)
	);

	rvv_lsu #(
		.VLEN (VLEN)
	) i_rvv_lsu (
		.clk          (clk),
		.resetn       (resetn),
		.run_i        (run),
		.op_i         (op),
		.vtype_i      (vtype),
		.vl_i         (vl),
		.rs1_i        (pcpi_rs1_i),
		.mem_done_i   (pcpi_mem_done_i),
		.mem_rdata_i  (pcpi_mem_rdata_i),
		.vreg_rdata_i (vreg_rdata),
		.mem_req_o    (mem_req),
		.vreg_raddr_o (vreg_raddr),
		.vreg_waddr_o (vreg_waddr),
		.vreg_wstrb_o (vreg_wstrb),
		.vreg_wdata_o (vreg_wdata),
		.ready_o      (lsu_ready),
		.wait_o       (lsu_wait)
	);

	rvv_vregs #(
		.VLEN           (VLEN),
		.REGS_INIT_ZERO (REGS_INIT_ZERO)
	) i_rvv_vregs (
		.clk     (clk),
		.waddr_i (vreg_waddr),
		.wstrb_i (vreg_wstrb),
		.wdata_i (vreg_wdata),
		.raddr_i (vreg_raddr),
		.rdata_o (vreg_rdata)
	);

endmodule

// File: design/rvv_vregs.sv
`timescale 1ns/1ps

module rvv_vregs #(
	parameter int unsigned VLEN           = 128,
	parameter bit          REGS_INIT_ZERO = 1'b0
) (
	input  logic              clk,
	input  logic [4:0]        waddr_i,
	input  logic [VLEN/8-1:0] wstrb_i,
	input  logic [VLEN-1:0]   wdata_i,
	input  logic [4:0]        raddr_i,
	output logic [VLEN-1:0]   rdata_o
);
	logic [VLEN-1:0] regs_q [32];

	initial begin
		if (REGS_INIT_ZERO) begin
			for (int r = 0; r < 32; r++)
				regs_q[r] = '0;
		end
	end

	always @(posedge clk) begin
		for (int b = 0; b < VLEN / 8; b++) begin
			if (wstrb_i[b])
				regs_q[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
		end
	end

	assign rdata_o = regs_q[raddr_i]; // async read

endmodule

// File: design/rvv_lsu.sv
`timescale 1ns/1ps

module rvv_lsu #(
	parameter int unsigned VLEN = 128
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    run_i,
	input  rvv_isa_pkg::rvv_op_t    op_i,
	input  rvv_state_pkg::vtype_t   vtype_i,
	input  logic [31:0]             vl_i,
	input  logic [31:0]             rs1_i,
	input  logic                    mem_done_i,
	input  logic [31:0]             mem_rdata_i,
	input  logic [VLEN-1:0]         vreg_rdata_i,
	output rvv_state_pkg::mem_req_t mem_req_o,
	output logic [4:0]              vreg_raddr_o,
	output logic [4:0]              vreg_waddr_o,
	output logic [VLEN/8-1:0]       vreg_wstrb_o,
	output logic [VLEN-1:0]         vreg_wdata_o,
	output logic                    ready_o,
	output logic                    wait_o
);
	localparam int unsigned VLENB  = VLEN / 8;
	localparam int unsigned WIDX_W = $clog2(VLEN / 32); // words per register

	logic              send_q; // 1: issue request next, 0: waiting for done
	logic [31:0]       elem_q;
	logic [WIDX_W-1:0] widx;   // word slot inside the register
	logic [4:0]        ridx;   // register offset from vd
	logic              is_load;
	logic              is_store;
	logic              mem_run;
	logic              last_elem;
	logic [31:0]       store_word;

	assign is_load = op_i.kind == rvv_isa_pkg::KIND_LOAD;
	assign is_store = op_i.kind == rvv_isa_pkg::KIND_STORE;
	assign mem_run = run_i && (is_load || is_store);

	assign widx = elem_q[WIDX_W-1:0];
	assign ridx = elem_q[WIDX_W +: 5]; // wraps past v31
	assign last_elem = elem_q == vl_i - 32'd1;

	assign vreg_raddr_o = op_i.vd + ridx;
	assign store_word = vreg_rdata_i[{widx, 5'd0} +: 32];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wait_o <= 1'b0;
			ready_o <= 1'b0;
			send_q <= 1'b0;
			elem_q <= '0;
			mem_req_o.wen <= 1'b0;
			mem_req_o.ftrans <= 1'b0;
			vreg_wstrb_o <= '0;
		end else begin
			ready_o <= 1'b0;
			mem_req_o.wen <= 1'b0;
			mem_req_o.ftrans <= 1'b0;
			vreg_wstrb_o <= '0;

			if (!wait_o) begin
				if (mem_run) begin
					elem_q <= '0;
					if (vl_i == '0 || vtype_i.vill) begin
						ready_o <= 1'b1; // nothing to move
					end else begin
						wait_o <= 1'b1;
						send_q <= 1'b1;
					end
				end
			end else if (send_q) begin
				mem_req_o.wen <= 1'b1;
				mem_req_o.ftrans <= elem_q == '0;
				mem_req_o.addr <= rs1_i + {elem_q[29:0], 2'b00};
				mem_req_o.wdata <= store_word;
				mem_req_o.strb <= {4{is_store}};
				send_q <= 1'b0;
			end else if (mem_done_i) begin
				if (is_load) begin
					vreg_waddr_o <= op_i.vd + ridx;
					vreg_wstrb_o <= VLENB'(4'hf) << {widx, 2'b00};
					vreg_wdata_o <= VLEN'(mem_rdata_i) << {widx, 5'd0};
				end
				if (last_elem) begin
					wait_o <= 1'b0;
					ready_o <= 1'b1;
				end else begin
					elem_q <= elem_q + 32'd1;
					send_q <= 1'b1;
				end
			end
			// no done yet, hold everything
		end
	end

endmodule

// File: design/rvv_csr.sv
`timescale 1ns/1ps

module rvv_csr #(
	parameter int unsigned VLEN = 128
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  run_i,
	input  rvv_isa_pkg::rvv_op_t  op_i,
	input  logic [31:0]           rs1_i,
	input  logic [31:0]           rs2_i,
	output rvv_state_pkg::vtype_t vtype_o,
	output logic [31:0]           vl_o,
	output logic                  ready_o,
	output logic                  wr_o,
	output logic [31:0]           rd_o
);
	rvv_state_pkg::vtype_t vtype_new;
	logic [31:0] vlmax_base;
	logic [31:0] vlmax;
	logic [31:0] avl;
	logic [31:0] vl_new;
	logic        cfg_run;

	assign cfg_run = run_i && op_i.kind == rvv_isa_pkg::KIND_CFG;

	always_comb begin
		if (op_i.cfg == rvv_isa_pkg::CFG_VSETVL)
			vtype_new = rs2_i;
		else
			vtype_new = {24'd0, op_i.vtypei};
	end

	// elements per register, sew = 8 << vsew
	assign vlmax_base = 32'(VLEN) >> ({1'b0, vtype_new.vsew} + 4'd3);

	always_comb begin
		case (vtype_new.vlmul)
			3'b100: vlmax = '0; // reserved lmul
			3'b101: vlmax = vlmax_base >> 3; // mf8
			3'b110: vlmax = vlmax_base >> 2;
			3'b111: vlmax = vlmax_base >> 1;
			default: vlmax = vlmax_base << vtype_new.vlmul[1:0];
		endcase
		if (vtype_new.vill || vtype_new.reserved != '0)
			vlmax = '0; // vsetvl with a bad rs2
	end

	always_comb begin
		if (op_i.cfg == rvv_isa_pkg::CFG_VSETIVLI)
			avl = {27'd0, op_i.rs1};
		else if (op_i.rs1 != 5'd0)
			avl = rs1_i;
		else if (op_i.vd != 5'd0)
			avl = '1; // ask for vlmax
		else
			avl = vl_o; // keep vl, change vtype only
	end

	assign vl_new = (avl < vlmax) ? avl : vlmax;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_o <= rvv_state_pkg::VTYPE_RESET;
			vl_o <= '0;
			ready_o <= 1'b0;
			wr_o <= 1'b0;
		end else begin
			ready_o <= cfg_run;
			wr_o <= cfg_run;
			if (cfg_run) begin
				vtype_o <= (vlmax == '0) ? rvv_state_pkg::VTYPE_RESET : vtype_new;
				vl_o <= vl_new;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_run)
			rd_o <= vl_new; // new vl back to rd
	end

endmodule

// File: design/rvv_decode.sv
`timescale 1ns/1ps

module rvv_decode (
	input  logic [31:0]          pcpi_insn_i,
	output rvv_isa_pkg::rvv_op_t op_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       unit_e32;

	assign opcode = pcpi_insn_i[6:0];
	assign funct3 = pcpi_insn_i[14:12];

	// nf=0, mew=0, mop=unit, lumop=0 and 32-bit width
	assign unit_e32 = pcpi_insn_i[31:26] == 6'b000000 && pcpi_insn_i[24:20] == 5'b00000
		&& funct3 == rvv_isa_pkg::WIDTH_E32;

	always_comb begin
		op_o = '0;
		op_o.vd = pcpi_insn_i[11:7];
		op_o.rs1 = pcpi_insn_i[19:15];
		op_o.vtypei = pcpi_insn_i[27:20];

		if (opcode == rvv_isa_pkg::OPC_V && funct3 == rvv_isa_pkg::F3_CFG) begin
			if (!pcpi_insn_i[31]) begin
				op_o.kind = rvv_isa_pkg::KIND_CFG;
				op_o.cfg = rvv_isa_pkg::CFG_VSETVLI;
			end else if (pcpi_insn_i[31:30] == 2'b11) begin
				op_o.kind = rvv_isa_pkg::KIND_CFG;
				op_o.cfg = rvv_isa_pkg::CFG_VSETIVLI;
			end else if (pcpi_insn_i[31:25] == 7'b1000000) begin
				op_o.kind = rvv_isa_pkg::KIND_CFG;
				op_o.cfg = rvv_isa_pkg::CFG_VSETVL;
			end
		end else if (opcode == rvv_isa_pkg::OPC_VLOAD && unit_e32) begin
			op_o.kind = rvv_isa_pkg::KIND_LOAD;
		end else if (opcode == rvv_isa_pkg::OPC_VSTORE && unit_e32) begin
			op_o.kind = rvv_isa_pkg::KIND_STORE;
		end
		// arithmetic and other widths stay KIND_NONE
	end

endmodule

// File: design/rvv_state_pkg.sv
package rvv_state_pkg;

	typedef struct packed {
		logic        vill;
		logic [22:0] reserved;
		logic        vma;
		logic        vta;
		logic [2:0]  vsew;
		logic [2:0]  vlmul;
	} vtype_t;

	// illegal config until the first vset*
	localparam vtype_t VTYPE_RESET = 32'h8000_0000;

	// one element transfer toward the core
	typedef struct packed {
		logic        wen;
		logic        ftrans; // first transfer of the instruction
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
	} mem_req_t;

endpackage

// File: design/rvv_isa_pkg.sv
package rvv_isa_pkg;

	// major opcodes
	localparam logic [6:0] OPC_V      = 7'b1010111;
	localparam logic [6:0] OPC_VLOAD  = 7'b0000111;
	localparam logic [6:0] OPC_VSTORE = 7'b0100111;

	localparam logic [2:0] F3_CFG    = 3'b111; // OP-V funct3 for vset*
	localparam logic [2:0] WIDTH_E32 = 3'b110; // memory width field, 32-bit elements

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_CFG,
		KIND_LOAD,
		KIND_STORE
	} rvv_kind_e;

	typedef enum logic [1:0] {
		CFG_VSETVLI,
		CFG_VSETIVLI,
		CFG_VSETVL
	} rvv_cfg_e;

	typedef struct packed {
		rvv_kind_e  kind;
		rvv_cfg_e   cfg;
		logic [4:0] vd;     // vd, or vs3 for stores
		logic [4:0] rs1;    // rs1 number, uimm for vsetivli
		logic [7:0] vtypei; // vma, vta, vsew, vlmul
	} rvv_op_t;

endpackage
